// ==== ao_peripheral_subsystem/ao_peripheral_subsystem.sv ====
// --------------------------------------------------------------------------
// Always-on peripherals: exit registers, the power manager for bank and
// peripheral clock gates and peripheral reset, and the 8-pin GPIO.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "mcu_config.svh"

module ao_peripheral_subsystem
  import mcu_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  obi_req_t                     slave_req_i,
  output obi_resp_t                    slave_resp_o,
  input  logic [`MCU_AO_GPIO_PINS-1:0] gpio_i,
  output logic [`MCU_AO_GPIO_PINS-1:0] gpio_o,
  output logic [`MCU_AO_GPIO_PINS-1:0] gpio_oe_o,
  output logic [`MCU_AO_GPIO_PINS-1:0] gpio_intr_o,
  output logic                         exit_valid_o,
  output logic [31:0]                  exit_value_o,
  output logic [`MCU_NUM_BANKS-1:0]    mem_clkgate_en_no,
  output logic                         periph_clkgate_en_no,
  output logic                         periph_rst_no
);

  obi_req_t                  gpio_req;
  logic [31:0]               gpio_rdata;
  logic                      gpio_sel;
  logic                      gpio_sel_q;
  logic                      wr;
  logic                      rvalid_q;
  logic                      rd_q;
  logic [31:0]               reg_rdata;
  logic [31:0]               reg_rdata_q;
  logic [`MCU_NUM_BANKS-1:0] mem_gate_q;
  logic [1:0]                periph_ctrl_q;
  logic                      periph_rst_q;

  // addr[8] picks the GPIO over the local registers
  assign gpio_sel = slave_req_i.addr[8];
  assign wr       = slave_req_i.req && slave_req_i.we && !gpio_sel;

  always_comb begin
    gpio_req     = slave_req_i;
    gpio_req.req = slave_req_i.req && gpio_sel;
  end

  always_comb begin
    case (slave_req_i.addr[7:2])
      6'd0:    reg_rdata = 32'(exit_valid_o);
      6'd1:    reg_rdata = exit_value_o;
      6'd2:    reg_rdata = 32'(mem_gate_q);
      6'd3:    reg_rdata = 32'(periph_ctrl_q);
      default: reg_rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_valid_o  <= 1'b0;
      exit_value_o  <= '0;
      mem_gate_q    <= '0;
      periph_ctrl_q <= '0;
    end else if (wr) begin
      case (slave_req_i.addr[7:2])
        6'd0:    exit_valid_o  <= slave_req_i.wdata[0];
        6'd1:    exit_value_o  <= slave_req_i.wdata;
        6'd2:    mem_gate_q    <= slave_req_i.wdata[`MCU_NUM_BANKS-1:0];
        6'd3:    periph_ctrl_q <= slave_req_i.wdata[1:0];
        default: ;
      endcase
    end
  end

  // Peripheral reset flop also follows the global reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q     <= 1'b0;
      rd_q         <= 1'b0;
      periph_rst_q <= 1'b0;
    end else begin
      rvalid_q     <= slave_req_i.req;
      rd_q         <= slave_req_i.req && !slave_req_i.we;
      periph_rst_q <= !periph_ctrl_q[1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (slave_req_i.req) begin
      gpio_sel_q  <= gpio_sel;
      reg_rdata_q <= reg_rdata;
    end
  end

  assign slave_resp_o.gnt    = slave_req_i.req;
  assign slave_resp_o.rvalid = rvalid_q;
  assign slave_resp_o.rdata  = !rd_q ? '0 : (gpio_sel_q ? gpio_rdata : reg_rdata_q);

  // Active-low enables are the inverted gate bits
  assign mem_clkgate_en_no    = ~mem_gate_q;
  assign periph_clkgate_en_no = ~periph_ctrl_q[0];
  assign periph_rst_no        = periph_rst_q;

  gpio #(
    .NUM_PINS(`MCU_AO_GPIO_PINS)
  ) ao_gpio_i (
    .clk_i,
    .rst_n_i,
    .en_i     (1'b1),
    .req_i    (gpio_req),
    .gpio_i,
    .rdata_o  (gpio_rdata),
    .gpio_o,
    .gpio_oe_o,
    .intr_o   (gpio_intr_o)
  );

endmodule

`default_nettype wire

// ==== common/mcu_config.svh ====
// --------------------------------------------------------------------------
// Build constants for the MCU: memory banking, address map, pad counts and
// interrupt vector positions. Include in any file that needs them.
// --------------------------------------------------------------------------
`ifndef MCU_CONFIG_SVH
`define MCU_CONFIG_SVH

// On-chip memory of 1 KiB per bank
`define MCU_NUM_BANKS   2
`define MCU_BANK_WORDS  256
`define MCU_MEM_BASE    32'h0000_0000

// Peripheral regions decoded on addr[31:28]
`define MCU_AO_PERIPH_BASE  32'h2000_0000
`define MCU_PERIPH_BASE     32'h3000_0000

// Pads
`define MCU_AO_GPIO_PINS  8
`define MCU_GPIO_PINS     24

// Bit positions in the core interrupt vector
`define MCU_IRQ_SOFTWARE      3
`define MCU_IRQ_EXTERNAL      11
`define MCU_IRQ_GPIO_AO_BASE  23

`endif

// ==== common/mcu_pkg.sv ====
// --------------------------------------------------------------------------
// Shared bus types: the simplified OBI request and response and the slave
// select used by the bus decoder.
// --------------------------------------------------------------------------
`default_nettype none

package mcu_pkg;

  // OBI request, 70 bits
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  // OBI response, 34 bits
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  typedef enum logic [1:0] {
    SEL_MEM,
    SEL_AO,
    SEL_PERIPH,
    SEL_NONE
  } slave_sel_e;

endpackage

`default_nettype wire

// ==== hw/core_v_mini_mcu.sv ====
// --------------------------------------------------------------------------
// MCU top level. One external bus master reaches memory and both peripheral
// subsystems, and irq_o carries the interrupt vector for an outside core.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "mcu_config.svh"

module core_v_mini_mcu
  import mcu_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  obi_req_t                     ext_master_req_i,
  output obi_resp_t                    ext_master_resp_o,
  input  logic [`MCU_AO_GPIO_PINS-1:0] gpio_ao_i,
  output logic [`MCU_AO_GPIO_PINS-1:0] gpio_ao_o,
  output logic [`MCU_AO_GPIO_PINS-1:0] gpio_ao_oe_o,
  input  logic [`MCU_GPIO_PINS-1:0]    gpio_i,
  output logic [`MCU_GPIO_PINS-1:0]    gpio_o,
  output logic [`MCU_GPIO_PINS-1:0]    gpio_oe_o,
  output logic                         exit_valid_o,
  output logic [31:0]                  exit_value_o,
  output logic [31:0]                  irq_o
);

  obi_req_t                     mem_req;
  obi_resp_t                    mem_resp;
  obi_req_t                     ao_req;
  obi_resp_t                    ao_resp;
  obi_req_t                     periph_req;
  obi_resp_t                    periph_resp;
  logic [`MCU_NUM_BANKS-1:0]    mem_clkgate_en_n;
  logic                         periph_clkgate_en_n;
  logic                         periph_rst_n;
  logic [`MCU_AO_GPIO_PINS-1:0] gpio_ao_intr;
  logic                         irq_software;
  logic                         irq_external;

  always_comb begin
    irq_o                                             = '0;
    irq_o[`MCU_IRQ_SOFTWARE]                          = irq_software;
    irq_o[`MCU_IRQ_EXTERNAL]                          = irq_external;
    irq_o[`MCU_IRQ_GPIO_AO_BASE +: `MCU_AO_GPIO_PINS] = gpio_ao_intr;
  end

  system_bus system_bus_i (
    .clk_i,
    .rst_n_i,
    .master_req_i (ext_master_req_i),
    .master_resp_o(ext_master_resp_o),
    .mem_req_o    (mem_req),
    .mem_resp_i   (mem_resp),
    .ao_req_o     (ao_req),
    .ao_resp_i    (ao_resp),
    .periph_req_o (periph_req),
    .periph_resp_i(periph_resp)
  );

  memory_subsystem memory_subsystem_i (
    .clk_i,
    .rst_n_i,
    .ram_req_i     (mem_req),
    .ram_resp_o    (mem_resp),
    .clk_gate_en_ni(mem_clkgate_en_n)
  );

  ao_peripheral_subsystem ao_peripheral_subsystem_i (
    .clk_i,
    .rst_n_i,
    .slave_req_i         (ao_req),
    .slave_resp_o        (ao_resp),
    .gpio_i              (gpio_ao_i),
    .gpio_o              (gpio_ao_o),
    .gpio_oe_o           (gpio_ao_oe_o),
    .gpio_intr_o         (gpio_ao_intr),
    .exit_valid_o,
    .exit_value_o,
    .mem_clkgate_en_no   (mem_clkgate_en_n),
    .periph_clkgate_en_no(periph_clkgate_en_n),
    .periph_rst_no       (periph_rst_n)
  );

  // Reset comes from the power manager, not the pad
  peripheral_subsystem peripheral_subsystem_i (
    .clk_i,
    .rst_n_i       (periph_rst_n),
    .clk_gate_en_ni(periph_clkgate_en_n),
    .slave_req_i   (periph_req),
    .slave_resp_o  (periph_resp),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .irq_software_o(irq_software),
    .irq_external_o(irq_external)
  );

endmodule

`default_nettype wire

// ==== hw/gpio.sv ====
// --------------------------------------------------------------------------
// Register-mapped GPIO with a two-flop input synchronizer and rising-edge
// interrupts. The parent raises req only for accesses to this block.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gpio
  import mcu_pkg::*;
#(
  parameter int unsigned NUM_PINS = 8
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                en_i,
  input  obi_req_t            req_i,
  input  logic [NUM_PINS-1:0] gpio_i,
  output logic [31:0]         rdata_o,
  output logic [NUM_PINS-1:0] gpio_o,
  output logic [NUM_PINS-1:0] gpio_oe_o,
  output logic [NUM_PINS-1:0] intr_o
);

  logic [NUM_PINS-1:0] sync_q;
  logic [NUM_PINS-1:0] data_in_q;
  logic [NUM_PINS-1:0] prev_q;
  logic [NUM_PINS-1:0] intr_en_q;
  logic [NUM_PINS-1:0] status_q;
  logic [NUM_PINS-1:0] rise;
  logic [NUM_PINS-1:0] clr;
  logic [2:0]          reg_idx;
  logic                wr;
  logic [31:0]         rd_val;

  assign reg_idx = req_i.addr[4:2];
  assign wr      = req_i.req && req_i.we;
  assign rise    = data_in_q & ~prev_q;
  // INTR_STATUS is write-one-to-clear
  assign clr     = (wr && reg_idx == 3'd4) ? req_i.wdata[NUM_PINS-1:0] : '0;

  always_comb begin
    case (reg_idx)
      3'd0:    rd_val = 32'(data_in_q);
      3'd1:    rd_val = 32'(gpio_o);
      3'd2:    rd_val = 32'(gpio_oe_o);
      3'd3:    rd_val = 32'(intr_en_q);
      3'd4:    rd_val = 32'(status_q);
      default: rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q    <= '0;
      data_in_q <= '0;
      prev_q    <= '0;
      gpio_o    <= '0;
      gpio_oe_o <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
    end else if (en_i) begin
      sync_q    <= gpio_i;
      data_in_q <= sync_q;
      prev_q    <= data_in_q;
      status_q  <= (status_q & ~clr) | (rise & intr_en_q);
      if (wr) begin
        case (reg_idx)
          3'd1:    gpio_o    <= req_i.wdata[NUM_PINS-1:0];
          3'd2:    gpio_oe_o <= req_i.wdata[NUM_PINS-1:0];
          3'd3:    intr_en_q <= req_i.wdata[NUM_PINS-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i && req_i.req && !req_i.we) begin
      rdata_o <= rd_val;
    end
  end

  assign intr_o = status_q;

endmodule

`default_nettype wire

// ==== hw/system_bus.sv ====
// --------------------------------------------------------------------------
// Single-master system bus. Decodes the region from addr[31:28], forwards
// the request to one slave and routes its response back a cycle later.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "mcu_config.svh"

module system_bus
  import mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  obi_req_t  master_req_i,
  output obi_resp_t master_resp_o,
  output obi_req_t  mem_req_o,
  input  obi_resp_t mem_resp_i,
  output obi_req_t  ao_req_o,
  input  obi_resp_t ao_resp_i,
  output obi_req_t  periph_req_o,
  input  obi_resp_t periph_resp_i
);

  localparam logic [31:0] MEM_BASE    = `MCU_MEM_BASE;
  localparam logic [31:0] AO_BASE     = `MCU_AO_PERIPH_BASE;
  localparam logic [31:0] PERIPH_BASE = `MCU_PERIPH_BASE;

  slave_sel_e sel;
  slave_sel_e sel_q;
  logic       gnt;
  logic       none_rvalid_q;

  always_comb begin
    case (master_req_i.addr[31:28])
      MEM_BASE[31:28]:    sel = SEL_MEM;
      AO_BASE[31:28]:     sel = SEL_AO;
      PERIPH_BASE[31:28]: sel = SEL_PERIPH;
      default:            sel = SEL_NONE;
    endcase
  end

  // Only the selected slave sees req
  always_comb begin
    mem_req_o        = master_req_i;
    ao_req_o         = master_req_i;
    periph_req_o     = master_req_i;
    mem_req_o.req    = master_req_i.req && (sel == SEL_MEM);
    ao_req_o.req     = master_req_i.req && (sel == SEL_AO);
    periph_req_o.req = master_req_i.req && (sel == SEL_PERIPH);
  end

  always_comb begin
    case (sel)
      SEL_MEM:    gnt = mem_resp_i.gnt;
      SEL_AO:     gnt = ao_resp_i.gnt;
      SEL_PERIPH: gnt = periph_resp_i.gnt;
      default:    gnt = master_req_i.req;
    endcase
  end

  // Remember who was granted so the response comes from the right slave
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q         <= SEL_NONE;
      none_rvalid_q <= 1'b0;
    end else begin
      none_rvalid_q <= gnt && (sel == SEL_NONE);
      if (gnt) begin
        sel_q <= sel;
      end
    end
  end

  always_comb begin
    master_resp_o.gnt = gnt;
    case (sel_q)
      SEL_MEM: begin
        master_resp_o.rvalid = mem_resp_i.rvalid;
        master_resp_o.rdata  = mem_resp_i.rdata;
      end
      SEL_AO: begin
        master_resp_o.rvalid = ao_resp_i.rvalid;
        master_resp_o.rdata  = ao_resp_i.rdata;
      end
      SEL_PERIPH: begin
        master_resp_o.rvalid = periph_resp_i.rvalid;
        master_resp_o.rdata  = periph_resp_i.rdata;
      end
      default: begin
        master_resp_o.rvalid = none_rvalid_q;
        master_resp_o.rdata  = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/mcu_pkg.sv
hw/gpio.sv
memory_subsystem/sram_bank.sv
memory_subsystem/memory_subsystem.sv
ao_peripheral_subsystem/ao_peripheral_subsystem.sv
peripheral_subsystem/peripheral_subsystem.sv
hw/system_bus.sv
hw/core_v_mini_mcu.sv
verification/tb_core_v_mini_mcu.sv

// ==== memory_subsystem/memory_subsystem.sv ====
// --------------------------------------------------------------------------
// Banked on-chip RAM. The bank index sits above the word index, and a bank
// whose clock-gate enable is low takes no accesses but keeps its contents.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "mcu_config.svh"

module memory_subsystem
  import mcu_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  obi_req_t                  ram_req_i,
  output obi_resp_t                 ram_resp_o,
  input  logic [`MCU_NUM_BANKS-1:0] clk_gate_en_ni
);

  localparam int unsigned BANK_BITS = $clog2(`MCU_NUM_BANKS);
  localparam int unsigned WORD_BITS = $clog2(`MCU_BANK_WORDS);

  logic [BANK_BITS-1:0]      bank_sel;
  logic [BANK_BITS-1:0]      bank_sel_q;
  logic [`MCU_NUM_BANKS-1:0] bank_en;
  logic [31:0]               bank_rdata [`MCU_NUM_BANKS];
  logic                      rvalid_q;
  logic                      rd_q;

  assign bank_sel = ram_req_i.addr[WORD_BITS+2 +: BANK_BITS];

  for (genvar i = 0; i < `MCU_NUM_BANKS; i++) begin : gen_bank
    assign bank_en[i] = ram_req_i.req && (bank_sel == i) && clk_gate_en_ni[i];

    sram_bank #(
      .NUM_WORDS(`MCU_BANK_WORDS)
    ) sram_bank_i (
      .clk_i,
      .en_i   (bank_en[i]),
      .we_i   (ram_req_i.we),
      .be_i   (ram_req_i.be),
      .addr_i (ram_req_i.addr[WORD_BITS+1:2]),
      .wdata_i(ram_req_i.wdata),
      .rdata_o(bank_rdata[i])
    );
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      rd_q     <= 1'b0;
    end else begin
      rvalid_q <= ram_req_i.req;
      // Writes and gated reads answer with zero
      rd_q     <= (|bank_en) && !ram_req_i.we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ram_req_i.req) begin
      bank_sel_q <= bank_sel;
    end
  end

  assign ram_resp_o.gnt    = ram_req_i.req;
  assign ram_resp_o.rvalid = rvalid_q;
  assign ram_resp_o.rdata  = rd_q ? bank_rdata[bank_sel_q] : '0;

endmodule

`default_nettype wire

// ==== memory_subsystem/sram_bank.sv ====
// --------------------------------------------------------------------------
// Word-addressed synchronous RAM bank with byte enables. Read data is valid
// one cycle after a read with en_i high.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sram_bank #(
  parameter int unsigned NUM_WORDS = 256
) (
  input  logic                         clk_i,
  input  logic                         en_i,
  input  logic                         we_i,
  input  logic [3:0]                   be_i,
  input  logic [$clog2(NUM_WORDS)-1:0] addr_i,
  input  logic [31:0]                  wdata_i,
  output logic [31:0]                  rdata_o
);

  logic [31:0] mem [NUM_WORDS];

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[b]) begin
            mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== peripheral_subsystem/peripheral_subsystem.sv ====
// --------------------------------------------------------------------------
// Switchable peripherals: 24-pin GPIO and the software interrupt register.
// Clock gate and reset come from the always-on power manager.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "mcu_config.svh"

module peripheral_subsystem
  import mcu_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      clk_gate_en_ni,
  input  obi_req_t                  slave_req_i,
  output obi_resp_t                 slave_resp_o,
  input  logic [`MCU_GPIO_PINS-1:0] gpio_i,
  output logic [`MCU_GPIO_PINS-1:0] gpio_o,
  output logic [`MCU_GPIO_PINS-1:0] gpio_oe_o,
  output logic                      irq_software_o,
  output logic                      irq_external_o
);

  obi_req_t                  gpio_req;
  logic [31:0]               gpio_rdata;
  logic [`MCU_GPIO_PINS-1:0] gpio_intr;
  logic                      gpio_sel;
  logic                      gpio_sel_q;
  logic                      msip_hit;
  logic                      rvalid_q;
  logic                      rd_q;
  logic                      msip_q;
  logic                      msip_rdata_q;

  assign gpio_sel = slave_req_i.addr[8];
  assign msip_hit = !gpio_sel && (slave_req_i.addr[7:2] == 6'd0);

  always_comb begin
    gpio_req     = slave_req_i;
    gpio_req.req = slave_req_i.req && gpio_sel;
  end

  // Gated accesses are still granted and answer with zero
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      rd_q     <= 1'b0;
      msip_q   <= 1'b0;
    end else begin
      rvalid_q <= slave_req_i.req;
      rd_q     <= slave_req_i.req && !slave_req_i.we && clk_gate_en_ni;
      if (clk_gate_en_ni && slave_req_i.req && slave_req_i.we && msip_hit) begin
        msip_q <= slave_req_i.wdata[0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (slave_req_i.req) begin
      gpio_sel_q   <= gpio_sel;
      msip_rdata_q <= msip_hit && msip_q;
    end
  end

  assign slave_resp_o.gnt    = slave_req_i.req;
  assign slave_resp_o.rvalid = rvalid_q;
  assign slave_resp_o.rdata  = !rd_q ? '0 : (gpio_sel_q ? gpio_rdata : 32'(msip_rdata_q));

  assign irq_software_o = msip_q;
  assign irq_external_o = |gpio_intr;

  gpio #(
    .NUM_PINS(`MCU_GPIO_PINS)
  ) periph_gpio_i (
    .clk_i,
    .rst_n_i,
    .en_i     (clk_gate_en_ni),
    .req_i    (gpio_req),
    .gpio_i,
    .rdata_o  (gpio_rdata),
    .gpio_o,
    .gpio_oe_o,
    .intr_o   (gpio_intr)
  );

endmodule

`default_nettype wire

// ==== verification/tb_core_v_mini_mcu.sv ====
// ----------------------------------------------------------------------------
// Directed testbench for the MCU top level. It drives the external bus master
// and the pads, and checks memory, gating, GPIO, interrupts and exit registers.
// ----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "mcu_config.svh"

module tb_core_v_mini_mcu
  import mcu_pkg::*;
();

  localparam time         DRIVE_DLY   = 1ns;
  localparam int          TIMEOUT     = 20;
  localparam logic [31:0] MEM_BASE    = `MCU_MEM_BASE;
  localparam logic [31:0] AO_BASE     = `MCU_AO_PERIPH_BASE;
  localparam logic [31:0] PERIPH_BASE = `MCU_PERIPH_BASE;
  // Register offsets with the GPIO block at 0x100 in each region
  localparam logic [31:0] EXIT_VALID  = 32'h00;
  localparam logic [31:0] EXIT_VALUE  = 32'h04;
  localparam logic [31:0] MEM_CLKGATE = 32'h08;
  localparam logic [31:0] PERIPH_CTRL = 32'h0C;
  localparam logic [31:0] MSIP        = 32'h00;
  localparam logic [31:0] GPIO_IN     = 32'h100;
  localparam logic [31:0] GPIO_OUT    = 32'h104;
  localparam logic [31:0] GPIO_OE     = 32'h108;
  localparam logic [31:0] GPIO_IEN    = 32'h10C;
  localparam logic [31:0] GPIO_STAT   = 32'h110;

  logic                         clk_i;
  logic                         rst_n_i;
  obi_req_t                     bus_req;
  obi_resp_t                    ext_master_resp_o;
  logic [`MCU_AO_GPIO_PINS-1:0] gpio_ao_i;
  logic [`MCU_AO_GPIO_PINS-1:0] gpio_ao_o;
  logic [`MCU_AO_GPIO_PINS-1:0] gpio_ao_oe_o;
  logic [`MCU_GPIO_PINS-1:0]    gpio_i;
  logic [`MCU_GPIO_PINS-1:0]    gpio_o;
  logic [`MCU_GPIO_PINS-1:0]    gpio_oe_o;
  logic                         exit_valid_o;
  logic [31:0]                  exit_value_o;
  logic [31:0]                  irq_o;

  core_v_mini_mcu core_v_mini_mcu_i (
    .clk_i,
    .rst_n_i,
    .ext_master_req_i (bus_req),
    .ext_master_resp_o,
    .gpio_ao_i,
    .gpio_ao_o,
    .gpio_ao_oe_o,
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .exit_valid_o,
    .exit_value_o,
    .irq_o
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic end_with_failure();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: time %0t %s got %h expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_ao_pads(input string name, input logic [`MCU_AO_GPIO_PINS-1:0] got,
                               input logic [`MCU_AO_GPIO_PINS-1:0] exp);
    if (got !== exp) begin
      $display("error: time %0t %s got %h expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_pads(input string name, input logic [`MCU_GPIO_PINS-1:0] got,
                            input logic [`MCU_GPIO_PINS-1:0] exp);
    if (got !== exp) begin
      $display("error: time %0t %s got %h expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  // One OBI access with req held until grant
  task automatic bus_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int cycles;
    @(posedge clk_i);
    #DRIVE_DLY;
    bus_req.req   = 1'b1;
    bus_req.we    = we;
    bus_req.be    = be;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    cycles = 0;
    @(negedge clk_i);
    while (!ext_master_resp_o.gnt && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!ext_master_resp_o.gnt) begin
      $display("no grant for the access to address %h", addr);
      end_with_failure();
    end
    if (ext_master_resp_o.rvalid) begin
      $display("rvalid came in the grant cycle at address %h", addr);
      end_with_failure();
    end
    @(posedge clk_i);
    #DRIVE_DLY;
    bus_req = '0;
    @(negedge clk_i);
    cycles = 1;
    while (!ext_master_resp_o.rvalid && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!ext_master_resp_o.rvalid) begin
      $display("no rvalid for the access to address %h", addr);
      end_with_failure();
    end
    if (cycles != 1) begin
      $display("rvalid came %0d cycles after the grant at address %h", cycles, addr);
      end_with_failure();
    end
    rdata = ext_master_resp_o.rdata;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be = 4'hf);
    logic [31:0] rdata;
    bus_access(1'b1, be, addr, data, rdata);
    check_word("write rdata", rdata, 32'h0);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(1'b0, 4'hf, addr, 32'h0, data);
  endtask

  task automatic read_expect(input string name, input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    bus_read(addr, data);
    check_word(name, data, exp);
  endtask

  // Pad inputs pass a synchronizer, so keep reading until the value shows
  task automatic poll_read(input string name, input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    int          tries;
    tries = 0;
    bus_read(addr, data);
    while (data !== exp && tries < TIMEOUT) begin
      bus_read(addr, data);
      tries++;
    end
    if (data !== exp) begin
      $display("%s never read %h, last value %h", name, exp, data);
      end_with_failure();
    end
  endtask

  task automatic wait_irq(input int idx);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!irq_o[idx] && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!irq_o[idx]) begin
      $display("interrupt bit %0d was never raised", idx);
      end_with_failure();
    end
  endtask

  task automatic drive_ao_pads(input logic [`MCU_AO_GPIO_PINS-1:0] value);
    @(posedge clk_i);
    #DRIVE_DLY;
    gpio_ao_i = value;
  endtask

  task automatic drive_pads(input logic [`MCU_GPIO_PINS-1:0] value);
    @(posedge clk_i);
    #DRIVE_DLY;
    gpio_i = value;
  endtask

  task automatic reset_state_test();
    @(negedge clk_i);
    check_word("exit_valid_o", 32'(exit_valid_o), 32'h0);
    check_word("exit_value_o", exit_value_o, 32'h0);
    check_ao_pads("gpio_ao_oe_o", gpio_ao_oe_o, '0);
    check_ao_pads("gpio_ao_o", gpio_ao_o, '0);
    check_pads("gpio_oe_o", gpio_oe_o, '0);
    check_pads("gpio_o", gpio_o, '0);
    check_word("irq_o", irq_o, 32'h0);
  endtask

  task automatic memory_test();
    logic [31:0] addr [8];
    logic [31:0] data [8];
    logic [31:0] exp;
    logic [31:0] patch;
    logic [3:0]  be;
    for (int i = 0; i < 8; i++) begin
      addr[i] = MEM_BASE + ((i % 2) << 10) + ((i * 7 + 3) << 2);
      data[i] = $urandom();
      bus_write(addr[i], data[i]);
    end
    for (int i = 0; i < 8; i++) begin
      read_expect("ram rdata", addr[i], data[i]);
    end
    // Partial write touches only the enabled bytes
    patch = 32'haabbccdd;
    be    = 4'b0110;
    exp   = data[1];
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        exp[8*b +: 8] = patch[8*b +: 8];
      end
    end
    bus_write(addr[1], patch, be);
    read_expect("ram partial write", addr[1], exp);
    read_expect("unmapped rdata", 32'h5000_0000, 32'h0);
  endtask

  task automatic bank_gating_test();
    logic [31:0] word;
    word = $urandom();
    bus_write(MEM_BASE + 32'h440, word);
    bus_write(AO_BASE + MEM_CLKGATE, 32'h2);
    read_expect("MEM_CLKGATE", AO_BASE + MEM_CLKGATE, 32'h2);
    bus_write(MEM_BASE + 32'h440, ~word);
    read_expect("gated bank rdata", MEM_BASE + 32'h440, 32'h0);
    bus_write(MEM_BASE + 32'h040, 32'h1234_5678);
    read_expect("bank 0 rdata", MEM_BASE + 32'h040, 32'h1234_5678);
    bus_write(AO_BASE + MEM_CLKGATE, 32'h0);
    read_expect("ungated bank rdata", MEM_BASE + 32'h440, word);
  endtask

  task automatic gpio_test();
    logic [`MCU_AO_GPIO_PINS-1:0] pins;
    bus_write(AO_BASE + GPIO_OE, 32'hff);
    bus_write(AO_BASE + GPIO_OUT, 32'ha5);
    check_ao_pads("gpio_ao_oe_o", gpio_ao_oe_o, 8'hff);
    check_ao_pads("gpio_ao_o", gpio_ao_o, 8'ha5);
    drive_ao_pads(8'h3c);
    poll_read("ao DATA_IN", AO_BASE + GPIO_IN, 32'h3c);
    bus_write(PERIPH_BASE + GPIO_OE, 32'hff_ffff);
    bus_write(PERIPH_BASE + GPIO_OUT, 32'h5a_5a5a);
    check_pads("gpio_oe_o", gpio_oe_o, 24'hff_ffff);
    check_pads("gpio_o", gpio_o, 24'h5a_5a5a);
    drive_pads(24'h12_3456);
    poll_read("DATA_IN", PERIPH_BASE + GPIO_IN, 32'h12_3456);

    // One new rising edge per always-on pin
    drive_ao_pads('0);
    poll_read("ao DATA_IN", AO_BASE + GPIO_IN, 32'h0);
    bus_write(AO_BASE + GPIO_IEN, 32'hff);
    pins = '0;
    for (int k = 0; k < `MCU_AO_GPIO_PINS; k++) begin
      pins[k] = 1'b1;
      drive_ao_pads(pins);
      wait_irq(`MCU_IRQ_GPIO_AO_BASE + k);
      check_word("irq_o", irq_o, 32'h1 << (`MCU_IRQ_GPIO_AO_BASE + k));
      bus_write(AO_BASE + GPIO_STAT, 32'h1 << k);
      check_word("irq_o after clear", irq_o, 32'h0);
    end
    bus_write(AO_BASE + GPIO_IEN, 32'h0);
    drive_ao_pads('0);

    // Pin 3 is not enabled and must stay quiet
    drive_pads('0);
    poll_read("DATA_IN", PERIPH_BASE + GPIO_IN, 32'h0);
    bus_write(PERIPH_BASE + GPIO_IEN, 32'h200);
    drive_pads(24'h00_0208);
    wait_irq(`MCU_IRQ_EXTERNAL);
    check_word("irq_o", irq_o, 32'h1 << `MCU_IRQ_EXTERNAL);
    read_expect("INTR_STATUS", PERIPH_BASE + GPIO_STAT, 32'h200);
    bus_write(PERIPH_BASE + GPIO_STAT, 32'h200);
    check_word("irq_o after clear", irq_o, 32'h0);
  endtask

  task automatic periph_power_test();
    bus_write(PERIPH_BASE + MSIP, 32'h1);
    check_word("irq_o", irq_o, 32'h1 << `MCU_IRQ_SOFTWARE);
    read_expect("MSIP", PERIPH_BASE + MSIP, 32'h1);
    bus_write(AO_BASE + PERIPH_CTRL, 32'h1);
    read_expect("gated MSIP", PERIPH_BASE + MSIP, 32'h0);
    read_expect("gated DATA_OUT", PERIPH_BASE + GPIO_OUT, 32'h0);
    bus_write(PERIPH_BASE + MSIP, 32'h0);
    bus_write(PERIPH_BASE + GPIO_OUT, 32'h0);
    check_word("irq_o while gated", irq_o, 32'h1 << `MCU_IRQ_SOFTWARE);
    check_pads("gpio_o while gated", gpio_o, 24'h5a_5a5a);
    bus_write(AO_BASE + PERIPH_CTRL, 32'h0);
    read_expect("DATA_OUT", PERIPH_BASE + GPIO_OUT, 32'h5a_5a5a);
    read_expect("MSIP", PERIPH_BASE + MSIP, 32'h1);
    // Reset-hold pulse
    bus_write(AO_BASE + PERIPH_CTRL, 32'h2);
    read_expect("PERIPH_CTRL", AO_BASE + PERIPH_CTRL, 32'h2);
    bus_write(AO_BASE + PERIPH_CTRL, 32'h0);
    read_expect("MSIP after reset", PERIPH_BASE + MSIP, 32'h0);
    read_expect("OUT_EN after reset", PERIPH_BASE + GPIO_OE, 32'h0);
    check_word("irq_o after reset", irq_o, 32'h0);
    check_pads("gpio_o after reset", gpio_o, '0);
    check_pads("gpio_oe_o after reset", gpio_oe_o, '0);
  endtask

  task automatic exit_regs_test();
    logic [31:0] value;
    value = $urandom();
    bus_write(AO_BASE + EXIT_VALUE, value);
    check_word("exit_value_o", exit_value_o, value);
    check_word("exit_valid_o", 32'(exit_valid_o), 32'h0);
    bus_write(AO_BASE + EXIT_VALID, 32'h1);
    check_word("exit_valid_o", 32'(exit_valid_o), 32'h1);
    check_word("exit_value_o", exit_value_o, value);
    read_expect("EXIT_VALUE", AO_BASE + EXIT_VALUE, value);
    read_expect("EXIT_VALID", AO_BASE + EXIT_VALID, 32'h1);
  endtask

  initial begin
    void'($urandom(32'hc1cd));
    rst_n_i   = 1'b0;
    bus_req   = '0;
    gpio_ao_i = '0;
    gpio_i    = '0;
    repeat (5) @(posedge clk_i);
    #DRIVE_DLY;
    rst_n_i = 1'b1;

    reset_state_test();
    memory_test();
    bank_gating_test();
    gpio_test();
    periph_power_test();
    exit_regs_test();

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
